// File: design/sdram_settings.svh
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// cpu data word and its byte lanes
`define SDRAM_DATA_WIDTH 32
`define SDRAM_BYTES (`SDRAM_DATA_WIDTH / 8)

// sdram geometry
`define SDRAM_ROW_WIDTH 11
`define SDRAM_COL_WIDTH 8
`define SDRAM_BANK_BITS 2

// bank, row and column packed into one cpu word
`define SDRAM_CPU_ADDR_WIDTH (`SDRAM_BANK_BITS + `SDRAM_ROW_WIDTH + `SDRAM_COL_WIDTH)

// burst length one, cas latency two
`define SDRAM_MODE_REGISTER 'h20

// idle cycles owed after an auto-refresh
`define SDRAM_AUTOREFRESH_LATENCY 3

`define SDRAM_CLK_FREQUENCY 25000000

// 8 bits at 25 MHz, one refresh every 256 clocks
`define SDRAM_REFRESH_BITS ($clog2(`SDRAM_CLK_FREQUENCY / 65536) - 1)

`endif

// File: design/sdram_pkg.sv
`include "sdram_settings.svh"

package sdram_pkg;

    // bank sits in the top bits of the cpu address
    typedef struct packed {
        logic [`SDRAM_BANK_BITS-1:0] bank;
        logic [`SDRAM_ROW_WIDTH-1:0] row;
        logic [`SDRAM_COL_WIDTH-1:0] col;
    } cpu_addr_fields_t;

    typedef union packed {
        logic [`SDRAM_CPU_ADDR_WIDTH-1:0] flat;
        cpu_addr_fields_t                 fields;
    } cpu_addr_u;

    typedef struct packed {
        cpu_addr_u                    addr;
        logic [`SDRAM_DATA_WIDTH-1:0] wdata;
        // active low byte strobes, all high is a read
        logic [`SDRAM_BYTES-1:0]      nwr;
    } cpu_req_t;

    // sdram command pins
    typedef struct packed {
        logic                        ncs;
        logic                        nras;
        logic                        ncas;
        logic                        nwe;
        logic [`SDRAM_BANK_BITS-1:0] bank;
        logic [`SDRAM_ROW_WIDTH-1:0] addr;
        logic [`SDRAM_BYTES-1:0]     dqm;
    } sdram_cmd_t;

endpackage

// File: design/sdram_refresh_timer.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_refresh_timer (
    input  logic clk,
    input  logic nreset,
    input  logic refresh_grant,
    output logic refresh_pending
);

    logic [`SDRAM_REFRESH_BITS-1:0] interval_cnt;

    // free running, one wrap per refresh interval
    always_ff @(posedge clk) begin
        if (!nreset) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // held until the sequencer takes it
    always_ff @(posedge clk) begin
        if (!nreset) begin
            refresh_pending <= 1'b0;
        end else if (interval_cnt == '0) begin
            refresh_pending <= 1'b1;
        end else if (refresh_grant) begin
            refresh_pending <= 1'b0;
        end
    end

endmodule

// File: design/sdram_controller.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_controller (
    input  logic                         clk,
    input  logic                         nreset,
    input  logic                         cpu_req,
    input  sdram_pkg::cpu_req_t          req_in,
    output logic                         cpu_ack,
    output logic [`SDRAM_DATA_WIDTH-1:0] cpu_rdata,
    input  logic                         refresh_pending,
    output logic                         refresh_grant,
    output sdram_pkg::sdram_cmd_t        cmd,
    output logic [`SDRAM_DATA_WIDTH-1:0] sdram_wdata,
    input  logic [`SDRAM_DATA_WIDTH-1:0] sdram_rdata
);

    localparam int NUM_STATES = 10;

    // one-hot state vectors
    localparam logic [NUM_STATES-1:0] ST_MODE_SET = NUM_STATES'(1) << 0;
    localparam logic [NUM_STATES-1:0] ST_IDLE     = NUM_STATES'(1) << 1;
    localparam logic [NUM_STATES-1:0] ST_NOP1     = NUM_STATES'(1) << 2;
    localparam logic [NUM_STATES-1:0] ST_NOP2     = NUM_STATES'(1) << 3;
    localparam logic [NUM_STATES-1:0] ST_CAS      = NUM_STATES'(1) << 4;
    localparam logic [NUM_STATES-1:0] ST_NOP3     = NUM_STATES'(1) << 5;
    localparam logic [NUM_STATES-1:0] ST_NOP4     = NUM_STATES'(1) << 6;
    localparam logic [NUM_STATES-1:0] ST_READ     = NUM_STATES'(1) << 7;
    localparam logic [NUM_STATES-1:0] ST_REFRESH  = NUM_STATES'(1) << 8;
    localparam logic [NUM_STATES-1:0] ST_WAIT     = NUM_STATES'(1) << 9;

    // {ncs, nras, ncas, nwe}
    localparam logic [3:0] CMD_MRS      = 4'b0000;
    localparam logic [3:0] CMD_ACTIVATE = 4'b0011;
    localparam logic [3:0] CMD_READ     = 4'b0101;
    localparam logic [3:0] CMD_WRITE    = 4'b0100;
    localparam logic [3:0] CMD_REFRESH  = 4'b0001;
    localparam logic [3:0] CMD_NOP      = 4'b0111;
    localparam logic [3:0] CMD_DESELECT = 4'b1111;

    // a10 selects auto-precharge on read/write
    localparam int AP_BIT = 10;

    localparam int WAIT_BITS = $clog2(`SDRAM_AUTOREFRESH_LATENCY + 1);
    localparam logic [WAIT_BITS-1:0] WAIT_LAST = WAIT_BITS'(`SDRAM_AUTOREFRESH_LATENCY);

    localparam logic [`SDRAM_ROW_WIDTH-1:0] MODE_WORD = `SDRAM_MODE_REGISTER;

    logic [NUM_STATES-1:0]          state;
    logic [WAIT_BITS-1:0]           wait_cnt;
    logic                           is_read;
    logic                           req;
    sdram_pkg::cpu_addr_fields_t    addr_f;
    logic [`SDRAM_ROW_WIDTH-1:0]    cas_addr;

    assign addr_f  = req_in.addr.fields;
    assign is_read = &req_in.nwr;

    // a held request after its ack is not a new one
    assign req = cpu_req && !cpu_ack;

    assign sdram_wdata   = req_in.wdata;
    assign refresh_grant = (state == ST_REFRESH);

    // column in the low bits, auto-precharge set
    always_comb begin
        cas_addr = '0;
        cas_addr[`SDRAM_COL_WIDTH-1:0] = addr_f.col;
        cas_addr[AP_BIT] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_DESELECT;
            cpu_ack <= 1'b0;
            state   <= ST_MODE_SET;
        end else begin
            case (state)
                ST_MODE_SET: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_MRS;
                    cmd.bank <= '0;
                    cmd.addr <= MODE_WORD;
                    cmd.dqm  <= '1;
                    state    <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                    end
                    // refresh wins over a waiting cpu access
                    if (refresh_pending) begin
                        {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_REFRESH;
                        state <= ST_REFRESH;
                    end else if (req) begin
                        {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_ACTIVATE;
                        cmd.bank <= addr_f.bank;
                        cmd.addr <= addr_f.row;
                        state    <= ST_NOP1;
                    end else begin
                        {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_DESELECT;
                    end
                end
                ST_NOP1: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    state <= ST_NOP2;
                end
                ST_NOP2: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    state <= ST_CAS;
                end
                ST_CAS: begin
                    cmd.bank <= addr_f.bank;
                    cmd.addr <= cas_addr;
                    if (is_read) begin
                        {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_READ;
                        // masks low so read data is not blocked
                        cmd.dqm <= '0;
                        state   <= ST_NOP3;
                    end else begin
                        {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_WRITE;
                        cmd.dqm <= req_in.nwr;
                        cpu_ack <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                ST_NOP3: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    state <= ST_NOP4;
                end
                ST_NOP4: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    state <= ST_READ;
                end
                ST_READ: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    cpu_rdata <= sdram_rdata;
                    cpu_ack   <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_REFRESH: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    // this cycle already counts toward the latency
                    wait_cnt <= WAIT_BITS'(1);
                    state    <= ST_WAIT;
                end
                ST_WAIT: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_NOP;
                    if (wait_cnt == WAIT_LAST) begin
                        state <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} <= CMD_DESELECT;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/sdram_subsystem.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_subsystem (
    input  logic                         clk,
    input  logic                         nreset,
    input  logic                         cpu_req,
    input  sdram_pkg::cpu_req_t          req_in,
    output logic                         cpu_ack,
    output logic [`SDRAM_DATA_WIDTH-1:0] cpu_rdata,
    output logic                         sdram_clk,
    output sdram_pkg::sdram_cmd_t        cmd,
    output logic [`SDRAM_DATA_WIDTH-1:0] sdram_wdata,
    input  logic [`SDRAM_DATA_WIDTH-1:0] sdram_rdata
);

    logic refresh_pending;
    logic refresh_grant;

    // the device samples mid-cycle, when the registered pins have settled
    assign sdram_clk = ~clk;

    sdram_refresh_timer i_refresh_timer (
        .clk             (clk),
        .nreset          (nreset),
        .refresh_grant   (refresh_grant),
        .refresh_pending (refresh_pending)
    );

    sdram_controller i_controller (
        .clk             (clk),
        .nreset          (nreset),
        .cpu_req         (cpu_req),
        .req_in          (req_in),
        .cpu_ack         (cpu_ack),
        .cpu_rdata       (cpu_rdata),
        .refresh_pending (refresh_pending),
        .refresh_grant   (refresh_grant),
        .cmd             (cmd),
        .sdram_wdata     (sdram_wdata),
        .sdram_rdata     (sdram_rdata)
    );

endmodule

// File: testbench/sdram_chk.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_chk (
    input logic                  clk,
    input logic                  nreset,
    input logic                  cpu_req,
    input logic                  cpu_ack,
    input sdram_pkg::sdram_cmd_t cmd
);

    localparam int QUIET = `SDRAM_AUTOREFRESH_LATENCY + 1;

    logic       violation = 1'b0;
    logic [3:0] pins;
    logic       is_refresh;
    logic       is_quiet;
    logic       is_act;
    logic       is_rw;

    assign pins       = {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe};
    assign is_refresh = (pins == 4'b0001);
    assign is_quiet   = cmd.ncs || (pins == 4'b0111);
    assign is_act     = (pins == 4'b0011);
    assign is_rw      = (pins == 4'b0101) || (pins == 4'b0100);

    // only no-op or deselect for the latency window
    refresh_quiet: assert property (
        @(posedge clk) disable iff (!nreset)
        is_refresh |=> is_quiet [*QUIET]
    ) else begin
        $error("command issued inside the refresh quiet window");
        violation = 1'b1;
    end

    ack_held: assert property (
        @(posedge clk) disable iff (!nreset)
        cpu_ack && cpu_req |=> cpu_ack
    ) else begin
        $error("cpu_ack fell while cpu_req was high");
        violation = 1'b1;
    end

    // activate sits three clocks before its read or write
    rw_after_act: assert property (
        @(posedge clk) disable iff (!nreset)
        is_rw |-> cmd.addr[10] && $past(is_act, 3) && $past(cmd.bank, 3) == cmd.bank
    ) else begin
        $error("read/write without auto-precharge or matching activate");
        violation = 1'b1;
    end

endmodule

bind sdram_controller sdram_chk i_chk (
    .clk     (clk),
    .nreset  (nreset),
    .cpu_req (cpu_req),
    .cpu_ack (cpu_ack),
    .cmd     (cmd)
);

// File: testbench/sdram_tb.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_tb;

    localparam int NUM_OPS     = 240;
    localparam int ACK_TIMEOUT = 64;
    localparam int QUIET       = `SDRAM_AUTOREFRESH_LATENCY + 1;
    localparam int INTERVAL    = 1 << `SDRAM_REFRESH_BITS;
    localparam int BANKS       = 1 << `SDRAM_BANK_BITS;

    logic                         clk;
    logic                         nreset;
    logic                         cpu_req;
    sdram_pkg::cpu_req_t          cur_req;
    logic                         cpu_ack;
    logic [`SDRAM_DATA_WIDTH-1:0] cpu_rdata;
    logic                         sdram_clk;
    sdram_pkg::sdram_cmd_t        cmd;
    logic [`SDRAM_DATA_WIDTH-1:0] sdram_wdata;
    logic [`SDRAM_DATA_WIDTH-1:0] sdram_rdata;

    integer      seed = 32'h2823_efdb;
    int unsigned cycle_cnt = 0;

    // device model and reference memory
    logic [`SDRAM_ROW_WIDTH-1:0]  open_row [BANKS];
    logic [BANKS-1:0]             row_open = '0;
    logic [`SDRAM_DATA_WIDTH-1:0] dev_mem [int];
    logic [`SDRAM_DATA_WIDTH-1:0] ref_mem [int];
    logic [`SDRAM_DATA_WIDTH-1:0] rd_word;
    int                           rd_delay = 0;
    bit                           mode_seen = 1'b0;
    bit                           refresh_seen = 1'b0;
    int unsigned                  last_refresh = 0;
    int unsigned                  refresh_log [$];
    bit                           log_refresh = 1'b0;
    int                           refresh_total = 0;
    int                           rw_total = 0;
    logic [BANKS-1:0]             banks_hit = '0;

    sdram_subsystem i_dut (
        .clk         (clk),
        .nreset      (nreset),
        .cpu_req     (cpu_req),
        .req_in      (cur_req),
        .cpu_ack     (cpu_ack),
        .cpu_rdata   (cpu_rdata),
        .sdram_clk   (sdram_clk),
        .cmd         (cmd),
        .sdram_wdata (sdram_wdata),
        .sdram_rdata (sdram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // unwritten words read back a pattern of their full address
    function automatic logic [`SDRAM_DATA_WIDTH-1:0] fill_word(
        input logic [`SDRAM_CPU_ADDR_WIDTH-1:0] addr
    );
        logic [`SDRAM_DATA_WIDTH-1:0] w;
        w = addr;
        return (w * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    // bytes whose active-low mask bit is clear take the new value
    function automatic logic [`SDRAM_DATA_WIDTH-1:0] merge_bytes(
        input logic [`SDRAM_DATA_WIDTH-1:0] old_word,
        input logic [`SDRAM_DATA_WIDTH-1:0] new_word,
        input logic [`SDRAM_BYTES-1:0]      nmask
    );
        logic [`SDRAM_DATA_WIDTH-1:0] w;
        w = old_word;
        for (int i = 0; i < `SDRAM_BYTES; i++) begin
            if (!nmask[i]) begin
                w[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return w;
    endfunction

    // sdram device with cas latency two
    always @(posedge sdram_clk) begin : responder
        logic [3:0] pins;
        int         key;
        if (nreset) begin
            assert (clk === 1'b0)
            else value_error("sdram_clk does not rise on the falling edge of clk");
            if (rd_delay > 0) begin
                rd_delay = rd_delay - 1;
                if (rd_delay == 0) begin
                    sdram_rdata <= rd_word;
                end
            end
            pins = {cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe};
            if (!cmd.ncs && pins != 4'b0111) begin
                if (!mode_seen) begin
                    assert (pins == 4'b0000)
                    else value_error("first command after reset is not a mode register set");
                end
                if (refresh_seen) begin
                    assert (cycle_cnt - last_refresh > QUIET)
                    else value_error("command inside the refresh quiet window");
                end
            end
            case (pins)
                4'b0000: begin
                    assert (cmd.addr == `SDRAM_MODE_REGISTER && cmd.bank == '0)
                    else value_error("mode register set carries the wrong value");
                    mode_seen = 1'b1;
                end
                4'b0011: begin
                    assert (cmd.bank == cur_req.addr.fields.bank &&
                            cmd.addr == cur_req.addr.fields.row)
                    else value_error("activate does not carry the request bank and row");
                    open_row[cmd.bank] = cmd.addr;
                    row_open[cmd.bank] = 1'b1;
                end
                4'b0101, 4'b0100: begin
                    assert (row_open[cmd.bank] && cmd.addr[10] &&
                            cmd.bank == cur_req.addr.fields.bank &&
                            cmd.addr[`SDRAM_COL_WIDTH-1:0] == cur_req.addr.fields.col)
                    else value_error("read/write has wrong bank, column or precharge bit");
                    key = {cmd.bank, open_row[cmd.bank], cmd.addr[`SDRAM_COL_WIDTH-1:0]};
                    if (pins == 4'b0101) begin
                        assert (cmd.dqm == '0) else value_error("byte masks high on a read");
                        rd_word  = dev_mem.exists(key) ? dev_mem[key] : fill_word(key);
                        rd_delay = 2;
                    end else begin
                        dev_mem[key] = merge_bytes(
                            dev_mem.exists(key) ? dev_mem[key] : fill_word(key),
                            sdram_wdata, cmd.dqm);
                    end
                    // auto-precharge closes the row
                    row_open[cmd.bank] = 1'b0;
                    rw_total++;
                end
                4'b0001: begin
                    assert (row_open == '0) else value_error("refresh with a bank still open");
                    refresh_seen = 1'b1;
                    last_refresh = cycle_cnt;
                    refresh_total++;
                    if (log_refresh) begin
                        refresh_log.push_back(cycle_cnt);
                    end
                end
                4'b0111: begin
                end
                default: begin
                    if (!cmd.ncs) begin
                        value_error("unexpected sdram command");
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_controller.i_chk.violation) begin
            plain_error("a bound protocol assertion failed");
        end
    end

    task automatic check_idle_refresh();
        log_refresh = 1'b1;
        repeat (1000) begin
            @(posedge clk);
            #2;
            assert (!cpu_ack) else value_error("acknowledge high with no request");
        end
        log_refresh = 1'b0;
        assert (refresh_log.size() >= 3) else value_error("too few refreshes on an idle bus");
        for (int i = 1; i < refresh_log.size(); i++) begin
            assert (refresh_log[i] - refresh_log[i-1] == INTERVAL)
            else value_error($sformatf("refresh gap %0d cycles",
                                       refresh_log[i] - refresh_log[i-1]));
        end
    endtask

    task automatic do_access(input sdram_pkg::cpu_req_t req);
        logic [`SDRAM_DATA_WIDTH-1:0] expected;
        int key;
        int waited;
        int hold;
        int rw_before;
        bit is_read;
        is_read   = &req.nwr;
        key       = req.addr.flat;
        expected  = ref_mem.exists(key) ? ref_mem[key] : fill_word(req.addr.flat);
        rw_before = rw_total;
        banks_hit[req.addr.fields.bank] = 1'b1;
        cur_req = req;
        cpu_req = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > ACK_TIMEOUT) begin
                plain_error("cpu acknowledge never came after a request");
            end
        end while (!cpu_ack);
        assert (waited >= (is_read ? 7 : 4))
        else value_error($sformatf("acknowledge after only %0d clocks", waited));
        if (is_read) begin
            assert (cpu_rdata === expected)
            else value_error($sformatf("read at %h returned %h, expected %h",
                                       req.addr.flat, cpu_rdata, expected));
        end else begin
            ref_mem[key] = merge_bytes(expected, req.wdata, req.nwr);
        end
        hold = $unsigned($random(seed)) % 3;
        repeat (hold) begin
            @(posedge clk);
            #2;
            assert (cpu_ack) else value_error("acknowledge dropped while request held");
        end
        // address and data stay put until the next request
        cpu_req = 1'b0;
        waited  = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > ACK_TIMEOUT) begin
                plain_error("cpu acknowledge never went low after the request dropped");
            end
        end while (cpu_ack);
        assert (rw_total == rw_before + 1)
        else value_error("access did not issue exactly one read or write");
    endtask

    task automatic run_traffic();
        sdram_pkg::cpu_req_t req;
        logic [`SDRAM_CPU_ADDR_WIDTH-1:0] written [$];
        int pick;
        int refresh_before;
        refresh_before = refresh_total;
        for (int n = 0; n < NUM_OPS; n++) begin
            pick          = $unsigned($random(seed)) % 8;
            req.addr.flat = $random(seed);
            req.wdata     = $random(seed);
            req.nwr       = $random(seed);
            if (pick < 3) begin
                req.nwr = '1;
                if (pick < 2 && written.size() > 0) begin
                    req.addr.flat = written[$unsigned($random(seed)) % written.size()];
                end
            end else begin
                if (&req.nwr) begin
                    req.nwr[$unsigned($random(seed)) % `SDRAM_BYTES] = 1'b0;
                end
                written.push_back(req.addr.flat);
            end
            do_access(req);
        end
        assert (refresh_total > refresh_before)
        else value_error("no refresh interleaved with traffic");
        assert (&banks_hit) else value_error("not every bank was addressed");
    endtask

    initial begin
        nreset      = 1'b0;
        cpu_req     = 1'b0;
        cur_req     = '0;
        sdram_rdata = '0;
        repeat (2) @(posedge clk);
        #2;
        assert (cmd.ncs && cmd.nras && cmd.ncas && cmd.nwe && !cpu_ack)
        else value_error("command pins or acknowledge not idle in reset");
        nreset = 1'b1;
        @(posedge clk);
        #2;
        assert ({cmd.ncs, cmd.nras, cmd.ncas, cmd.nwe} == 4'b0000 &&
                cmd.addr == `SDRAM_MODE_REGISTER && !cpu_ack)
        else value_error("no mode register set on the first cycle after reset");
        check_idle_refresh();
        run_traffic();
        if (i_dut.i_controller.i_chk.violation) begin
            plain_error("a bound protocol assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+design
design/sdram_pkg.sv
design/sdram_refresh_timer.sv
design/sdram_controller.sv
design/sdram_subsystem.sv
testbench/sdram_chk.sv
testbench/sdram_tb.sv

// File: Bender.yml
package:
  name: sdram_subsystem

export_include_dirs:
  - design

sources:
  - target: rtl
    include_dirs:
      - design
    files:
      - design/sdram_pkg.sv
      - design/sdram_refresh_timer.sv
      - design/sdram_controller.sv
      - design/sdram_subsystem.sv

  - target: test
    include_dirs:
      - design
    files:
      - testbench/sdram_chk.sv
      - testbench/sdram_tb.sv
